// File: all.f
+incdir+common
common/lsu_pkg.sv
src/lsu/lsu_id_table.sv
src/lsu/lsu_core.sv
src/ooo_data_mem.sv
src/lsu_csr.sv
src/lsu_top.sv
verif/tb_lsu_top.sv

// File: common/lsu_consts.svh
/*
  Shared constants of the load/store subsystem: outstanding load count,
  ID width, data memory depth, register offsets and reset values.
  Include with the common folder on the include path.
*/
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// Outstanding loads and ID width
`define LSU_NUM_IDS 4
`define LSU_ID_W 2

// Data memory depth in 32-bit words
`define MEM_WORDS 64

// Register offsets on the Wishbone side
`define CSR_DELAY0 5'h00
`define CSR_DELAY1 5'h04
`define CSR_DELAY2 5'h08
`define CSR_DELAY3 5'h0C
`define CSR_LIMIT 5'h10
`define CSR_NLOAD 5'h14
`define CSR_NSTORE 5'h18
`define CSR_NERR 5'h1C

// Reset values
`define DELAY_RST 8'd1
`define LIMIT_RST 32'h0000_0100

`endif

// File: common/lsu_pkg.sv
/*
  Types shared by the load/store unit and the data memory.
  Compile this package before any module that imports it.
*/
`include "lsu_consts.svh"

package lsu_pkg;

  // Access size as carried on lsu_qsize_i
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } size_e;

  // Transaction ID of an outstanding load
  typedef logic [`LSU_ID_W-1:0] id_t;

  // What the response path needs to finish a load
  typedef struct packed {
    logic [4:0] tag;
    logic       sign_ext;
    logic [1:0] offset;
    size_e      size;
  } lsu_meta_t;

endpackage

// File: run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root.
# Exit status is 0 only when the run prints the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_lsu_top -f all.f
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit 1
fi

sim_output=$(./obj_dir/Vtb_lsu_top)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_output" | grep -qx "SIMULATION PASSED"; then
  exit 0
else
  exit 1
fi

// File: src/lsu/lsu_core.sv
/*
  Load/store unit core. Aligns store data and builds byte strobes on
  the way to memory, tracks each load by ID and on the way back
  shifts and extends the loaded word. Both paths are combinational.
*/
`timescale 1ns/1ps

module lsu_core (
  input  logic         clk_i,
  input  logic         rst_i,
  // Core request channel
  input  logic         lsu_qvalid_i,
  input  logic         lsu_qwrite_i,
  input  logic         lsu_qsigned_i,
  input  logic [31:0]  lsu_qaddr_i,
  input  logic [31:0]  lsu_qdata_i,
  input  logic [1:0]   lsu_qsize_i,
  input  logic [4:0]   lsu_qtag_i,
  output logic         lsu_qready_o,
  // Core response channel
  output logic         lsu_pvalid_o,
  output logic [31:0]  lsu_pdata_o,
  output logic [4:0]   lsu_ptag_o,
  output logic         lsu_perror_o,
  input  logic         lsu_pready_i,
  // Memory request channel
  output logic         data_qvalid_o,
  output logic         data_qwrite_o,
  output logic [31:0]  data_qaddr_o,
  output logic [31:0]  data_qdata_o,
  output logic [3:0]   data_qstrb_o,
  output lsu_pkg::id_t data_qid_o,
  input  logic         data_qready_i,
  // Memory response channel
  input  logic         data_pvalid_i,
  input  logic [31:0]  data_pdata_i,
  input  logic         data_perror_i,
  input  lsu_pkg::id_t data_pid_i,
  output logic         data_pready_o
);

  import lsu_pkg::*;

  logic        id_full;
  logic        id_push;
  logic        id_pop;
  lsu_meta_t   req_meta;
  lsu_meta_t   rsp_meta;
  logic [63:0] wdata_dbl;
  logic [31:0] rdata_shift;

  // ------------------------------------------------------------
  // Request path
  // ------------------------------------------------------------
  // Full table stalls stores too, keeps the handshake simple
  assign data_qvalid_o = lsu_qvalid_i & ~id_full;
  assign lsu_qready_o  = data_qready_i & ~id_full;
  assign data_qwrite_o = lsu_qwrite_i;
  assign data_qaddr_o  = {lsu_qaddr_i[31:2], 2'b00};

  // Only loads take an ID
  assign id_push = data_qvalid_o & data_qready_i & ~lsu_qwrite_i;

  assign req_meta = '{
    tag:      lsu_qtag_i,
    sign_ext: lsu_qsigned_i,
    offset:   lsu_qaddr_i[1:0],
    size:     size_e'(lsu_qsize_i)
  };

  // Byte enables from size and offset
  always_comb begin
    case (size_e'(lsu_qsize_i))
      SIZE_BYTE: data_qstrb_o = 4'b0001 << lsu_qaddr_i[1:0];
      SIZE_HALF: data_qstrb_o = 4'b0011 << lsu_qaddr_i[1:0];
      SIZE_WORD: data_qstrb_o = 4'b1111;
      default:   data_qstrb_o = 4'b0000;
    endcase
  end

  // Rotate left by offset bytes, upper half of the doubled word
  assign wdata_dbl    = {lsu_qdata_i, lsu_qdata_i} << {lsu_qaddr_i[1:0], 3'b000};
  assign data_qdata_o = wdata_dbl[63:32];

  // ------------------------------------------------------------
  // Response path
  // ------------------------------------------------------------
  // ID freed only once the core takes the response
  assign data_pready_o = lsu_pready_i;
  assign id_pop        = data_pvalid_i & data_pready_o;

  assign rdata_shift = data_pdata_i >> {rsp_meta.offset, 3'b000};

  // Extension by stored size and sign bit
  always_comb begin
    case (rsp_meta.size)
      SIZE_BYTE: lsu_pdata_o = {{24{rdata_shift[7] & rsp_meta.sign_ext}},
                                rdata_shift[7:0]};
      SIZE_HALF: lsu_pdata_o = {{16{rdata_shift[15] & rsp_meta.sign_ext}},
                                rdata_shift[15:0]};
      default:   lsu_pdata_o = rdata_shift;
    endcase
  end

  assign lsu_pvalid_o = data_pvalid_i;
  assign lsu_ptag_o   = rsp_meta.tag;
  assign lsu_perror_o = data_perror_i;

  lsu_id_table u_id_table (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .push_i     (id_push),
    .meta_i     (req_meta),
    .pop_i      (id_pop),
    .pop_id_i   (data_pid_i),
    .free_id_o  (data_qid_o),
    .full_o     (id_full),
    .pop_meta_o (rsp_meta)
  );

  // Size 3 has no meaning, strobe would be empty
  qsize_legal_a : assert property (@(posedge clk_i) disable iff (rst_i)
    lsu_qvalid_i |-> lsu_qsize_i != 2'b11)
    else $error("request with size encoding 3");

endmodule

// File: src/lsu/lsu_id_table.sv
/*
  ID table for outstanding loads. Hands out the lowest free ID,
  keeps the load metadata under that ID and releases it when the
  response is taken. Used inside lsu_core.
*/
`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsu_id_table (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               push_i,
  input  lsu_pkg::lsu_meta_t meta_i,
  input  logic               pop_i,
  input  lsu_pkg::id_t       pop_id_i,
  output lsu_pkg::id_t       free_id_o,
  output logic               full_o,
  output lsu_pkg::lsu_meta_t pop_meta_o
);

  import lsu_pkg::*;

  // One bit per ID, set while the ID is free
  logic [`LSU_NUM_IDS-1:0] avail_q;
  lsu_meta_t               meta_q [`LSU_NUM_IDS];

  // Lowest free ID wins, so scan from the top down
  always_comb begin
    free_id_o = '0;
    for (int i = `LSU_NUM_IDS - 1; i >= 0; i--) begin
      if (avail_q[i]) begin
        free_id_o = id_t'(i);
      end
    end
  end

  assign full_o     = ~|avail_q;
  assign pop_meta_o = meta_q[pop_id_i];

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      avail_q <= '1;
    end else begin
      if (push_i) begin
        avail_q[free_id_o] <= 1'b0;
      end
      // Never the same ID as a push in the same cycle
      if (pop_i) begin
        avail_q[pop_id_i] <= 1'b1;
      end
    end
  end

  // Metadata storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      meta_q[free_id_o] <= meta_i;
    end
  end

  // ------------------------------------------------------------
  // Assertions
  // ------------------------------------------------------------
  // Request side must gate its handshake on full_o
  push_free_a : assert property (@(posedge clk_i) disable iff (rst_i)
    push_i |-> avail_q[free_id_o])
    else $error("load pushed onto a taken ID");

  // Memory must only answer IDs that were handed out
  pop_taken_a : assert property (@(posedge clk_i) disable iff (rst_i)
    pop_i |-> !avail_q[pop_id_i])
    else $error("response for an ID that is not outstanding");

endmodule

// File: src/lsu_csr.sv
/*
  Wishbone classic register block. Holds the four load delays and
  the address limit for the data memory, and counts loads, stores
  and error responses. Ack comes one cycle after cyc and stb.
*/
`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsu_csr (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic        wb_we_i,
  input  logic [4:0]  wb_adr_i,
  input  logic [31:0] wb_dat_i,
  output logic [31:0] wb_dat_o,
  output logic        wb_ack_o,
  input  logic        ev_load_i,
  input  logic        ev_store_i,
  input  logic        ev_err_i,
  output logic [7:0]  delay0_o,
  output logic [7:0]  delay1_o,
  output logic [7:0]  delay2_o,
  output logic [7:0]  delay3_o,
  output logic [31:0] limit_o
);

  logic [7:0]  delay_q [4];
  logic [31:0] limit_q;
  logic [31:0] nload_q;
  logic [31:0] nstore_q;
  logic [31:0] nerr_q;
  logic [31:0] rdata;
  logic        acc;
  logic        wr;

  // New access only while no ack is out
  assign acc = wb_cyc_i & wb_stb_i & ~wb_ack_o;
  assign wr  = acc & wb_we_i;

  // Read mux
  always_comb begin
    case (wb_adr_i)
      `CSR_DELAY0: rdata = {24'd0, delay_q[0]};
      `CSR_DELAY1: rdata = {24'd0, delay_q[1]};
      `CSR_DELAY2: rdata = {24'd0, delay_q[2]};
      `CSR_DELAY3: rdata = {24'd0, delay_q[3]};
      `CSR_LIMIT:  rdata = limit_q;
      `CSR_NLOAD:  rdata = nload_q;
      `CSR_NSTORE: rdata = nstore_q;
      `CSR_NERR:   rdata = nerr_q;
      default:     rdata = 32'd0;
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      wb_ack_o <= 1'b0;
      limit_q  <= `LIMIT_RST;
      nload_q  <= 32'd0;
      nstore_q <= 32'd0;
      nerr_q   <= 32'd0;
      for (int i = 0; i < 4; i++) begin
        delay_q[i] <= `DELAY_RST;
      end
    end else begin
      wb_ack_o <= acc;
      if (wr) begin
        case (wb_adr_i)
          `CSR_DELAY0: delay_q[0] <= wb_dat_i[7:0];
          `CSR_DELAY1: delay_q[1] <= wb_dat_i[7:0];
          `CSR_DELAY2: delay_q[2] <= wb_dat_i[7:0];
          `CSR_DELAY3: delay_q[3] <= wb_dat_i[7:0];
          `CSR_LIMIT:  limit_q    <= wb_dat_i;
          default: ;
        endcase
      end
      // Counters, a write clears and wins over an event
      if (wr && wb_adr_i == `CSR_NLOAD) begin
        nload_q <= 32'd0;
      end else if (ev_load_i) begin
        nload_q <= nload_q + 32'd1;
      end
      if (wr && wb_adr_i == `CSR_NSTORE) begin
        nstore_q <= 32'd0;
      end else if (ev_store_i) begin
        nstore_q <= nstore_q + 32'd1;
      end
      if (wr && wb_adr_i == `CSR_NERR) begin
        nerr_q <= 32'd0;
      end else if (ev_err_i) begin
        nerr_q <= nerr_q + 32'd1;
      end
    end
  end

  // Read data lands with the ack
  always_ff @(posedge clk_i) begin
    if (acc) begin
      wb_dat_o <= rdata;
    end
  end

  assign delay0_o = delay_q[0];
  assign delay1_o = delay_q[1];
  assign delay2_o = delay_q[2];
  assign delay3_o = delay_q[3];
  assign limit_o  = limit_q;

  // Master holds stb until it sees the ack
  ack_with_stb_a : assert property (@(posedge clk_i) disable iff (rst_i)
    wb_ack_o |-> wb_cyc_i && wb_stb_i)
    else $error("ack without an active strobe");

endmodule

// File: src/lsu_top.sv
/*
  Top level of the load/store subsystem. Core request and response
  ports and the Wishbone register port face outward; the LSU, the
  out-of-order data memory and the register block sit inside.
*/
`timescale 1ns/1ps

module lsu_top (
  input  logic        clk_i,
  input  logic        rst_i,
  // Core side
  input  logic        lsu_qvalid_i,
  input  logic        lsu_qwrite_i,
  input  logic        lsu_qsigned_i,
  input  logic [31:0] lsu_qaddr_i,
  input  logic [31:0] lsu_qdata_i,
  input  logic [1:0]  lsu_qsize_i,
  input  logic [4:0]  lsu_qtag_i,
  output logic        lsu_qready_o,
  output logic        lsu_pvalid_o,
  output logic [31:0] lsu_pdata_o,
  output logic [4:0]  lsu_ptag_o,
  output logic        lsu_perror_o,
  input  logic        lsu_pready_i,
  // Wishbone classic
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic        wb_we_i,
  input  logic [4:0]  wb_adr_i,
  input  logic [31:0] wb_dat_i,
  output logic [31:0] wb_dat_o,
  output logic        wb_ack_o
);

  import lsu_pkg::*;

  // LSU to memory
  logic        data_qvalid;
  logic        data_qwrite;
  logic [31:0] data_qaddr;
  logic [31:0] data_qdata;
  logic [3:0]  data_qstrb;
  id_t         data_qid;
  logic        data_qready;
  logic        data_pvalid;
  logic [31:0] data_pdata;
  logic        data_perror;
  id_t         data_pid;
  logic        data_pready;
  // Register block to memory and back
  logic [7:0]  delay0;
  logic [7:0]  delay1;
  logic [7:0]  delay2;
  logic [7:0]  delay3;
  logic [31:0] limit;
  logic        ev_load;
  logic        ev_store;
  logic        ev_err;

  lsu_core u_lsu_core (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .lsu_qvalid_i  (lsu_qvalid_i),
    .lsu_qwrite_i  (lsu_qwrite_i),
    .lsu_qsigned_i (lsu_qsigned_i),
    .lsu_qaddr_i   (lsu_qaddr_i),
    .lsu_qdata_i   (lsu_qdata_i),
    .lsu_qsize_i   (lsu_qsize_i),
    .lsu_qtag_i    (lsu_qtag_i),
    .lsu_qready_o  (lsu_qready_o),
    .lsu_pvalid_o  (lsu_pvalid_o),
    .lsu_pdata_o   (lsu_pdata_o),
    .lsu_ptag_o    (lsu_ptag_o),
    .lsu_perror_o  (lsu_perror_o),
    .lsu_pready_i  (lsu_pready_i),
    .data_qvalid_o (data_qvalid),
    .data_qwrite_o (data_qwrite),
    .data_qaddr_o  (data_qaddr),
    .data_qdata_o  (data_qdata),
    .data_qstrb_o  (data_qstrb),
    .data_qid_o    (data_qid),
    .data_qready_i (data_qready),
    .data_pvalid_i (data_pvalid),
    .data_pdata_i  (data_pdata),
    .data_perror_i (data_perror),
    .data_pid_i    (data_pid),
    .data_pready_o (data_pready)
  );

  ooo_data_mem u_data_mem (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .data_qvalid_i (data_qvalid),
    .data_qwrite_i (data_qwrite),
    .data_qaddr_i  (data_qaddr),
    .data_qdata_i  (data_qdata),
    .data_qstrb_i  (data_qstrb),
    .data_qid_i    (data_qid),
    .data_qready_o (data_qready),
    .data_pvalid_o (data_pvalid),
    .data_pdata_o  (data_pdata),
    .data_perror_o (data_perror),
    .data_pid_o    (data_pid),
    .data_pready_i (data_pready),
    .delay0_i      (delay0),
    .delay1_i      (delay1),
    .delay2_i      (delay2),
    .delay3_i      (delay3),
    .limit_i       (limit),
    .ev_load_o     (ev_load),
    .ev_store_o    (ev_store),
    .ev_err_o      (ev_err)
  );

  lsu_csr u_csr (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .wb_cyc_i   (wb_cyc_i),
    .wb_stb_i   (wb_stb_i),
    .wb_we_i    (wb_we_i),
    .wb_adr_i   (wb_adr_i),
    .wb_dat_i   (wb_dat_i),
    .wb_dat_o   (wb_dat_o),
    .wb_ack_o   (wb_ack_o),
    .ev_load_i  (ev_load),
    .ev_store_i (ev_store),
    .ev_err_i   (ev_err),
    .delay0_o   (delay0),
    .delay1_o   (delay1),
    .delay2_o   (delay2),
    .delay3_o   (delay3),
    .limit_o    (limit)
  );

endmodule

// File: src/ooo_data_mem.sv
/*
  Data memory with out-of-order load responses. Stores write their
  strobed bytes at once and get no response. Each load sits in the
  slot of its ID for a delay picked by address bits 3:2, then the
  lowest expired slot answers. Delays and limit come from lsu_csr.
*/
`timescale 1ns/1ps
`include "lsu_consts.svh"

module ooo_data_mem (
  input  logic         clk_i,
  input  logic         rst_i,
  input  logic         data_qvalid_i,
  input  logic         data_qwrite_i,
  input  logic [31:0]  data_qaddr_i,
  input  logic [31:0]  data_qdata_i,
  input  logic [3:0]   data_qstrb_i,
  input  lsu_pkg::id_t data_qid_i,
  output logic         data_qready_o,
  output logic         data_pvalid_o,
  output logic [31:0]  data_pdata_o,
  output logic         data_perror_o,
  output lsu_pkg::id_t data_pid_o,
  input  logic         data_pready_i,
  input  logic [7:0]   delay0_i,
  input  logic [7:0]   delay1_i,
  input  logic [7:0]   delay2_i,
  input  logic [7:0]   delay3_i,
  input  logic [31:0]  limit_i,
  output logic         ev_load_o,
  output logic         ev_store_o,
  output logic         ev_err_o
);

  import lsu_pkg::*;

  localparam int unsigned AW = $clog2(`MEM_WORDS);

  logic [31:0]             mem_q [`MEM_WORDS];
  // Slot state, one slot per ID
  logic [`LSU_NUM_IDS-1:0] busy_q;
  logic [7:0]              cnt_q [`LSU_NUM_IDS];
  logic [31:0]             sdata_q [`LSU_NUM_IDS];
  logic [`LSU_NUM_IDS-1:0] serr_q;
  logic [`LSU_NUM_IDS-1:0] expired;
  // Response held under back-pressure
  logic                    lock_q;
  id_t                     lock_id_q;
  id_t                     pick_id;
  logic [AW-1:0]           widx;
  logic [7:0]              delay_sel;
  logic [7:0]              delay_eff;
  logic                    over_limit;
  logic                    ld_acc;
  logic                    st_acc;
  logic                    rsp_acc;

  // ------------------------------------------------------------
  // Request side
  // ------------------------------------------------------------
  assign widx          = data_qaddr_i[AW+1:2];
  assign over_limit    = data_qaddr_i >= limit_i;
  assign data_qready_o = data_qwrite_i | ~&busy_q;
  assign ld_acc        = data_qvalid_i & data_qready_o & ~data_qwrite_i;
  assign st_acc        = data_qvalid_i & data_qready_o & data_qwrite_i;

  always_comb begin
    case (data_qaddr_i[3:2])
      2'd0:    delay_sel = delay0_i;
      2'd1:    delay_sel = delay1_i;
      2'd2:    delay_sel = delay2_i;
      default: delay_sel = delay3_i;
    endcase
  end

  // Zero delay behaves as one cycle
  assign delay_eff = (delay_sel == 8'd0) ? 8'd1 : delay_sel;

  // ------------------------------------------------------------
  // Response side
  // ------------------------------------------------------------
  always_comb begin
    for (int i = 0; i < `LSU_NUM_IDS; i++) begin
      expired[i] = busy_q[i] & (cnt_q[i] == 8'd0);
    end
  end

  // Lowest expired ID
  always_comb begin
    pick_id = '0;
    for (int i = `LSU_NUM_IDS - 1; i >= 0; i--) begin
      if (expired[i]) begin
        pick_id = id_t'(i);
      end
    end
  end

  // A stalled response keeps its ID even if a lower one expires
  assign data_pid_o    = lock_q ? lock_id_q : pick_id;
  assign data_pvalid_o = |expired;
  assign data_pdata_o  = sdata_q[data_pid_o];
  assign data_perror_o = serr_q[data_pid_o];
  assign rsp_acc       = data_pvalid_o & data_pready_i;

  assign ev_load_o  = ld_acc;
  assign ev_store_o = st_acc;
  assign ev_err_o   = rsp_acc & data_perror_o;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      busy_q    <= '0;
      lock_q    <= 1'b0;
      lock_id_q <= '0;
      for (int i = 0; i < `LSU_NUM_IDS; i++) begin
        cnt_q[i] <= 8'd0;
      end
    end else begin
      lock_q    <= data_pvalid_o & ~data_pready_i;
      lock_id_q <= data_pid_o;
      for (int i = 0; i < `LSU_NUM_IDS; i++) begin
        if (busy_q[i] && cnt_q[i] != 8'd0) begin
          cnt_q[i] <= cnt_q[i] - 8'd1;
        end
      end
      if (rsp_acc) begin
        busy_q[data_pid_o] <= 1'b0;
      end
      if (ld_acc) begin
        busy_q[data_qid_i] <= 1'b1;
        cnt_q[data_qid_i]  <= delay_eff;
      end
    end
  end

  // Array and slot payload
  always_ff @(posedge clk_i) begin
    // Stores past the limit are dropped
    if (st_acc && !over_limit) begin
      for (int b = 0; b < 4; b++) begin
        if (data_qstrb_i[b]) begin
          mem_q[widx][8*b +: 8] <= data_qdata_i[8*b +: 8];
        end
      end
    end
    if (ld_acc) begin
      sdata_q[data_qid_i] <= mem_q[widx];
      serr_q[data_qid_i]  <= over_limit;
    end
  end

  // ------------------------------------------------------------
  // Assertions
  // ------------------------------------------------------------
  // ID table in lsu_core must never reuse a busy slot
  slot_free_a : assert property (@(posedge clk_i) disable iff (rst_i)
    ld_acc |-> !busy_q[data_qid_i])
    else $error("load for an ID whose slot is busy");

endmodule

// File: verif/lsu_input.txt
# kind size sign addr data tag expected, all hex; T lines give stall percent and test name
# S/L data is store data, or 1 for a load that must return an error; W/R addr is the register offset
T 20 store_load
S 2 0 00000000 a1b2c3d4 00 00000000
S 2 0 00000004 00000000 00 00000000
S 0 0 00000005 000000e7 00 00000000
S 1 0 00000006 00008001 00 00000000
S 2 0 00000008 12345678 00 00000000
S 0 0 0000000b 000000f0 00 00000000
S 2 0 0000000c 7f80ff01 00 00000000
L 2 0 00000000 00000000 01 a1b2c3d4
L 0 1 00000000 00000000 02 ffffffd4
L 0 0 00000001 00000000 03 000000c3
L 1 1 00000002 00000000 04 ffffa1b2
L 0 1 00000005 00000000 05 ffffffe7
L 1 0 00000006 00000000 06 00008001
L 0 1 0000000b 00000000 07 fffffff0
T 0 out_of_order
W 0 0 00 00000009 00 00000000
W 0 0 04 00000001 00 00000000
W 0 0 08 00000005 00 00000000
W 0 0 0c 00000003 00 00000000
L 2 0 00000000 00000000 0b a1b2c3d4
L 2 0 00000004 00000000 0c 8001e700
L 2 0 00000008 00000000 0d f0345678
L 2 0 0000000c 00000000 0e 7f80ff01
T 25 id_full
L 2 0 00000000 00000000 0f a1b2c3d4
L 2 0 00000008 00000000 10 f0345678
L 2 0 0000000c 00000000 11 7f80ff01
L 2 0 00000000 00000000 12 a1b2c3d4
L 2 0 00000004 00000000 13 8001e700
T 0 limit_error
W 0 0 10 00000040 00 00000000
L 2 0 00000080 00000001 14 00000000
L 0 0 00000044 00000001 15 00000000
L 2 0 0000000c 00000000 16 7f80ff01
W 0 0 10 00000100 00 00000000
T 0 csr_readback
R 0 0 00 00000000 00 00000009
R 0 0 04 00000000 00 00000001
R 0 0 08 00000000 00 00000005
R 0 0 0c 00000000 00 00000003
R 0 0 10 00000000 00 00000100
R 0 0 14 00000000 00 00000013
R 0 0 18 00000000 00 00000007
R 0 0 1c 00000000 00 00000002
W 0 0 14 00000000 00 00000000
R 0 0 14 00000000 00 00000000
T 60 backpressure
L 2 0 00000000 00000000 17 a1b2c3d4
L 0 1 0000000b 00000000 18 fffffff0
L 1 0 00000006 00000000 19 00008001
L 2 0 0000000c 00000000 1a 7f80ff01
L 0 0 00000003 00000000 1b 000000a1
L 1 1 00000000 00000000 1c ffffc3d4

// File: verif/tb_lsu_top.sv
/*
  Testbench for lsu_top. Reads operations and expected values from
  verif/lsu_input.txt, drives core requests and Wishbone accesses on
  the falling edge and checks load responses by tag, in any order.
  Run from the project root.
*/
`timescale 1ns/1ps
`include "lsu_consts.svh"

module tb_lsu_top;

  localparam int    HALF     = 20;
  localparam string VEC_FILE = "verif/lsu_input.txt";

  logic        clk_i;
  logic        rst_i;
  logic        lsu_qvalid_i;
  logic        lsu_qwrite_i;
  logic        lsu_qsigned_i;
  logic [31:0] lsu_qaddr_i;
  logic [31:0] lsu_qdata_i;
  logic [1:0]  lsu_qsize_i;
  logic [4:0]  lsu_qtag_i;
  logic        lsu_qready_o;
  logic        lsu_pvalid_o;
  logic [31:0] lsu_pdata_o;
  logic [4:0]  lsu_ptag_o;
  logic        lsu_perror_o;
  logic        lsu_pready_i;
  logic        wb_cyc_i;
  logic        wb_stb_i;
  logic        wb_we_i;
  logic [4:0]  wb_adr_i;
  logic [31:0] wb_dat_i;
  logic [31:0] wb_dat_o;
  logic        wb_ack_o;

  // Scoreboard by tag, main loop counts issues, monitor counts responses
  logic [31:0] exp_data [32];
  logic        exp_err [32];
  int          issue_cnt [32] = '{default: 0};
  int          taken_cnt [32] = '{default: 0};
  int          issued    = 0;
  int          done      = 0;
  int          err_cnt   = 0;
  int          check_cnt = 0;
  int          n_vec     = 0;
  int          n_tests   = 0;
  int          n_passed  = 0;
  int          stall_pct = 0;
  integer      seed;
  string       tname     = "none";
  logic        in_test   = 1'b0;
  int          test_err0;
  int          test_chk0;
  // Response seen under back-pressure in the last cycle
  logic        held_q    = 1'b0;
  logic [4:0]  held_tag;
  logic [31:0] held_data;
  // Delay registers as last written, and the first cycle each load may be taken
  int          delay_cfg [4] = '{default: `DELAY_RST};
  int          due_cyc [32];
  int          cyc_cnt   = 0;

  lsu_top dut (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .lsu_qvalid_i  (lsu_qvalid_i),
    .lsu_qwrite_i  (lsu_qwrite_i),
    .lsu_qsigned_i (lsu_qsigned_i),
    .lsu_qaddr_i   (lsu_qaddr_i),
    .lsu_qdata_i   (lsu_qdata_i),
    .lsu_qsize_i   (lsu_qsize_i),
    .lsu_qtag_i    (lsu_qtag_i),
    .lsu_qready_o  (lsu_qready_o),
    .lsu_pvalid_o  (lsu_pvalid_o),
    .lsu_pdata_o   (lsu_pdata_o),
    .lsu_ptag_o    (lsu_ptag_o),
    .lsu_perror_o  (lsu_perror_o),
    .lsu_pready_i  (lsu_pready_i),
    .wb_cyc_i      (wb_cyc_i),
    .wb_stb_i      (wb_stb_i),
    .wb_we_i       (wb_we_i),
    .wb_adr_i      (wb_adr_i),
    .wb_dat_i      (wb_dat_i),
    .wb_dat_o      (wb_dat_o),
    .wb_ack_o      (wb_ack_o)
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #HALF clk_i = ~clk_i;
    end
  end

  always @(posedge clk_i) begin
    cyc_cnt <= cyc_cnt + 1;
  end

  // Random response back-pressure, rate set per test
  initial begin
    seed         = 37;
    lsu_pready_i = 1'b1;
    forever begin
      @(negedge clk_i);
      lsu_pready_i = ($unsigned($random(seed)) % 100) >= stall_pct;
    end
  end

  // Watchdog, 200 cycles per vector line
  initial begin
    wait (n_vec > 0);
    repeat (200 * n_vec + 20) @(posedge clk_i);
    $display("Timeout: run did not end within %0d cycles", 200 * n_vec + 20);
    $display("SIMULATION FAILED");
    $finish;
  end

  // Delay register picked by address bits 3:2, never below one cycle
  function automatic int load_delay(input logic [31:0] addr);
    int d;
    d = delay_cfg[addr[3:2]];
    return (d == 0) ? 1 : d;
  endfunction

  // ------------------------------------------------------------
  // Response monitor
  // ------------------------------------------------------------
  task automatic check_response();
    logic [4:0] t;
    t = lsu_ptag_o;
    check_cnt++;
    assert (issue_cnt[t] != taken_cnt[t]) else begin
      $display("Error in %0s: response for tag %0d with no load in flight", tname, t);
      err_cnt++;
    end
    // Never before its delay; without stalls only arbitration may hold it back
    check_cnt++;
    assert (cyc_cnt >= due_cyc[t] &&
            (stall_pct != 0 || cyc_cnt < due_cyc[t] + `LSU_NUM_IDS)) else begin
      $display("Error in %0s: tag %0d taken at cycle %0d, first allowed cycle %0d",
               tname, t, cyc_cnt, due_cyc[t]);
      err_cnt++;
    end
    if (exp_err[t]) begin
      assert (lsu_perror_o) else begin
        $display("[FAIL] %0s tag %0d error flag: expected 1, actual 0", tname, t);
        err_cnt++;
      end
    end else begin
      assert (!lsu_perror_o && lsu_pdata_o === exp_data[t]) else begin
        $display("[FAIL] %0s tag %0d: expected %08h err 0, actual %08h err %0d",
                 tname, t, exp_data[t], lsu_pdata_o, lsu_perror_o);
        err_cnt++;
      end
    end
    taken_cnt[t] <= taken_cnt[t] + 1;
    done         <= done + 1;
  endtask

  always @(posedge clk_i) begin
    if (!rst_i) begin
      // A stalled response has to stay until taken
      assert (!held_q || lsu_pvalid_o) else begin
        $display("Error in %0s: response dropped while the core stalled it", tname);
        err_cnt++;
      end
      if (lsu_pvalid_o && held_q) begin
        check_cnt++;
        assert (lsu_ptag_o === held_tag && lsu_pdata_o === held_data) else begin
          $display("Error in %0s: response tag or data changed while stalled", tname);
          err_cnt++;
        end
      end
      if (lsu_pvalid_o && lsu_pready_i) begin
        check_response();
      end
      held_q    <= lsu_pvalid_o & ~lsu_pready_i;
      held_tag  <= lsu_ptag_o;
      held_data <= lsu_pdata_o;
    end
  end

  // ------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------
  task automatic wb_access(input logic we, input logic [4:0] adr,
                           input logic [31:0] wdat, input logic [31:0] expected);
    int waits;
    @(negedge clk_i);
    lsu_qvalid_i = 1'b0;
    wb_cyc_i     = 1'b1;
    wb_stb_i     = 1'b1;
    wb_we_i      = we;
    wb_adr_i     = adr;
    wb_dat_i     = wdat;
    waits        = 0;
    @(posedge clk_i);
    while (!wb_ack_o) begin
      waits++;
      @(posedge clk_i);
    end
    check_cnt++;
    assert (waits == 1) else begin
      $display("Error in %0s: ack came %0d cycles after the strobe", tname, waits);
      err_cnt++;
    end
    if (!we) begin
      check_cnt++;
      assert (wb_dat_o === expected) else begin
        $display("[FAIL] %0s reg 0x%02h: expected %08h, actual %08h",
                 tname, adr, expected, wb_dat_o);
        err_cnt++;
      end
    end else if (adr < `CSR_LIMIT) begin
      delay_cfg[adr[3:2]] = wdat[7:0];
    end
    @(negedge clk_i);
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  // Holds the request until taken; ready must follow the loads in flight
  task automatic issue_request(input logic is_load, input logic [1:0] size,
                               input logic sgn, input logic [31:0] addr,
                               input logic [31:0] data, input logic [4:0] tag,
                               input logic [31:0] expected);
    logic taken;
    @(negedge clk_i);
    lsu_qvalid_i  = 1'b1;
    lsu_qwrite_i  = ~is_load;
    lsu_qsigned_i = sgn;
    lsu_qaddr_i   = addr;
    lsu_qdata_i   = is_load ? 32'd0 : data;
    lsu_qsize_i   = size;
    lsu_qtag_i    = tag;
    taken         = 1'b0;
    while (!taken) begin
      @(posedge clk_i);
      check_cnt++;
      assert (lsu_qready_o == (issued - done < `LSU_NUM_IDS)) else begin
        $display("[FAIL] %0s qready with %0d loads in flight: expected %0d, actual %0d",
                 tname, issued - done, issued - done < `LSU_NUM_IDS, lsu_qready_o);
        err_cnt++;
      end
      taken = lsu_qready_o;
    end
    if (is_load) begin
      exp_data[tag] = expected;
      exp_err[tag]  = data[0];
      due_cyc[tag]  = cyc_cnt + load_delay(addr) + 1;
      issue_cnt[tag]++;
      issued++;
    end
  endtask

  // Drains the loads of the running test and reports it
  task automatic finish_test();
    if (in_test) begin
      @(negedge clk_i);
      lsu_qvalid_i = 1'b0;
      while (issued != done) begin
        @(posedge clk_i);
      end
      n_tests++;
      if (err_cnt == test_err0) begin
        n_passed++;
        $display("Test %0d %0s: ok, %0d checks", n_tests, tname, check_cnt - test_chk0);
      end else begin
        $display("Test %0d %0s: %0d errors in %0d checks", n_tests, tname,
                 err_cnt - test_err0, check_cnt - test_chk0);
      end
    end
  endtask

  task automatic count_vectors();
    int    fd;
    string line;
    fd = $fopen(VEC_FILE, "r");
    if (fd != 0) begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 2 && line.getc(0) != "#") begin
          n_vec++;
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic run_vectors();
    int          fd;
    int          n;
    string       line;
    logic [7:0]  kind;
    logic [31:0] f_size;
    logic [31:0] f_sign;
    logic [31:0] f_addr;
    logic [31:0] f_data;
    logic [31:0] f_tag;
    logic [31:0] f_exp;
    fd = $fopen(VEC_FILE, "r");
    while ($fgets(line, fd) != 0) begin
      if (line.len() > 2 && line.getc(0) != "#") begin
        kind = line.getc(0);
        if (kind == "T") begin
          finish_test();
          n         = $sscanf(line, "%c %d %s", kind, stall_pct, tname);
          in_test   = 1'b1;
          test_err0 = err_cnt;
          test_chk0 = check_cnt;
          if (n != 3) begin
            $display("Error: test header line could not be read: %s", line);
            err_cnt++;
          end
        end else begin
          n = $sscanf(line, "%c %h %h %h %h %h %h",
                      kind, f_size, f_sign, f_addr, f_data, f_tag, f_exp);
          if (n != 7) begin
            $display("Error: operation line could not be read: %s", line);
            err_cnt++;
          end else begin
            case (kind)
              "W": wb_access(1'b1, f_addr[4:0], f_data, f_exp);
              "R": wb_access(1'b0, f_addr[4:0], f_data, f_exp);
              "S", "L": issue_request(kind == "L", f_size[1:0], f_sign[0], f_addr,
                                      f_data, f_tag[4:0], f_exp);
              default: begin
                $display("Error: unknown operation kind in line %s", line);
                err_cnt++;
              end
            endcase
          end
        end
      end
    end
    $fclose(fd);
    finish_test();
  endtask

  initial begin
    rst_i         = 1'b1;
    lsu_qvalid_i  = 1'b0;
    lsu_qwrite_i  = 1'b0;
    lsu_qsigned_i = 1'b0;
    lsu_qaddr_i   = 32'd0;
    lsu_qdata_i   = 32'd0;
    lsu_qsize_i   = 2'd0;
    lsu_qtag_i    = 5'd0;
    wb_cyc_i      = 1'b0;
    wb_stb_i      = 1'b0;
    wb_we_i       = 1'b0;
    wb_adr_i      = 5'd0;
    wb_dat_i      = 32'd0;
    count_vectors();
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    if (n_vec == 0) begin
      $display("Error: no vectors could be read from %s", VEC_FILE);
      err_cnt++;
    end else begin
      run_vectors();
    end
    $display("Tests: %0d run, %0d passed; checks: %0d; errors: %0d",
             n_tests, n_passed, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule
